// ==== verification/accel_csr_testdata.txt ====
# op (R or W)  byte address (hex)  data (hex, write value or expected read value)  check outputs (0/1)
# reads and writes go out one per cycle, a check flag waits for the write to land first
R 0000 1000010000000000 0
R 0008 a8e137c052f9b4d6 0
R 0010 6e3a41c79b204d5f 0
R 0018 0000000000000000 0
R 0020 0000000000000000 1
W 0110 0000001234567fc0 1
R 0110 0000001234567fc0 0
W 0110 00000000000abcd5 0
R 0110 00000000000abcc0 1
W 0118 ffffffffa5c3f00d 0
R 0118 00000000a5c3f00d 1
W 0120 ffffc3a1b2c3d4e5 0
R 0120 000003a1b2c3d4e5 0
W 0128 123456780000a000 0
W 0130 0000000000001000 0
W 0138 0000000000020000 0
W 0140 00000200deadbe00 0
W 0148 ffffffff00ff00ff 0
W 0150 000000000badf00d 0
W 0158 0000000000000040 1
R 0128 000000000000a000 0
R 0130 0000000000001000 0
R 0138 0000000000020000 0
R 0140 00000200deadbe00 0
R 0148 0000000000ff00ff 0
R 0150 000000000badf00d 0
R 0158 0000000000000040 0
W 0000 ffffffffffffffff 0
W 0018 ffffffffffffffff 0
W 011c ffffffffffffffff 0
W 0124 ffffffffffffffff 0
W 0160 ffffffffffffffff 1
R 0000 1000010000000000 0
R 011c 0000000000000000 0
R 0124 0000000000000000 0
R 0160 0000000000000000 0
R 0200 0000000000000000 1

// ==== vlog.f ====
src/csr_pkg.sv
src/mmio_request_decode.sv
src/csr_register_file.sv
src/mmio_read_response.sv
src/accel_csr_top.sv
verification/accel_csr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CSR block testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
  -f vlog.f \
  --top-module accel_csr_tb \
  -o accel_csr_sim

./obj_dir/accel_csr_sim

// ==== verification/accel_csr_tb.sv ====
// Self-checking testbench for accel_csr_top, replays the MMIO operations of the test data file
module accel_csr_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                 clk;
  logic                 reset;
  logic                 mmio_rd_valid;
  logic                 mmio_wr_valid;
  csr_pkg::mmio_addr_t  mmio_address;
  csr_pkg::mmio_tid_t   mmio_tid;
  csr_pkg::mmio_data_t  mmio_wr_data;
  logic                 rsp_valid;
  csr_pkg::mmio_tid_t   rsp_tid;
  csr_pkg::mmio_data_t  rsp_data;
  csr_pkg::hc_control_t hc_control;
  csr_pkg::cl_addr_t    hc_dsm_base;
  csr_pkg::cl_addr_t    buffer_address [csr_pkg::BUFFER_COUNT];
  csr_pkg::buf_size_t   buffer_size [csr_pkg::BUFFER_COUNT];

  // Expected register outputs, built from the write rules
  csr_pkg::hc_control_t exp_control;
  csr_pkg::cl_addr_t    exp_dsm_base;
  csr_pkg::cl_addr_t    exp_buf_addr [csr_pkg::BUFFER_COUNT];
  csr_pkg::buf_size_t   exp_buf_size [csr_pkg::BUFFER_COUNT];

  // Outstanding reads, oldest first
  csr_pkg::mmio_tid_t  exp_tid_q [$];
  csr_pkg::mmio_data_t exp_data_q [$];
  int                  exp_cycle_q [$];

  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  accel_csr_top u_dut (
    .clk            (clk),
    .reset          (reset),
    .mmio_rd_valid  (mmio_rd_valid),
    .mmio_wr_valid  (mmio_wr_valid),
    .mmio_address   (mmio_address),
    .mmio_tid       (mmio_tid),
    .mmio_wr_data   (mmio_wr_data),
    .rsp_valid      (rsp_valid),
    .rsp_tid        (rsp_tid),
    .rsp_data       (rsp_data),
    .hc_control     (hc_control),
    .hc_dsm_base    (hc_dsm_base),
    .buffer_address (buffer_address),
    .buffer_size    (buffer_size)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Cycle stamp for latency checks
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // ==================================================
  // Failure reporting and compares
  // ==================================================

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_data(input string what, input csr_pkg::mmio_data_t got,
                            input csr_pkg::mmio_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_tid(input string what, input csr_pkg::mmio_tid_t got,
                           input csr_pkg::mmio_tid_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_cl_addr(input string what, input csr_pkg::cl_addr_t got,
                               input csr_pkg::cl_addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_control(input string what, input csr_pkg::hc_control_t got,
                               input csr_pkg::hc_control_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_size(input string what, input csr_pkg::buf_size_t got,
                            input csr_pkg::buf_size_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_outputs();
    check_control("hc_control", hc_control, exp_control);
    check_cl_addr("hc_dsm_base", hc_dsm_base, exp_dsm_base);
    for (int i = 0; i < csr_pkg::BUFFER_COUNT; i++) begin
      check_cl_addr($sformatf("buffer_address[%0d]", i), buffer_address[i], exp_buf_addr[i]);
      check_size($sformatf("buffer_size[%0d]", i), buffer_size[i], exp_buf_size[i]);
    end
  endtask

  // ==================================================
  // Transaction IDs and the register model
  // ==================================================

  // Right-shifting Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = {1'b0, state[31:1]};
    if (state[0]) begin
      shifted = shifted ^ 32'h8020_0003;
    end
    return shifted;
  endfunction

  // One LFSR step per ID bit
  task automatic take_random_tid(output csr_pkg::mmio_tid_t tid);
    for (int i = 0; i < $bits(csr_pkg::mmio_tid_t); i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      tid[i] = lfsr_state[0];
    end
  endtask

  task automatic apply_write_model(input logic [15:0] byte_addr,
                                   input csr_pkg::mmio_data_t data);
    logic [15:0] offset;
    int          slot;
    // Addresses below the table wrap and fall out of range
    offset = byte_addr - 16'h0120;
    slot   = int'(offset[5:4]);
    if (byte_addr == 16'h0110) begin
      exp_dsm_base = csr_pkg::cl_addr_t'(data / 64'd64);
    end else if (byte_addr == 16'h0118) begin
      exp_control = data[31:0];
    end else if (offset < 16'h0040 && offset[2:0] == 3'b000) begin
      // Size sits 8 bytes above the address of its slot
      if (offset[3]) begin
        exp_buf_size[slot] = data[31:0];
      end else begin
        exp_buf_addr[slot] = data[41:0];
      end
    end
  endtask

  // ==================================================
  // Request driver and response monitor
  // ==================================================

  // Called 2 ns after an edge, returns 2 ns after the next one
  task automatic issue_op(input byte op, input logic [15:0] byte_addr,
                          input csr_pkg::mmio_data_t data);
    csr_pkg::mmio_tid_t tid;
    take_random_tid(tid);
    mmio_address = byte_addr >> 2;
    mmio_tid     = tid;
    if (op == "R") begin
      mmio_rd_valid = 1'b1;
      mmio_wr_data  = '0;
      exp_tid_q.push_back(tid);
      exp_data_q.push_back(data);
      exp_cycle_q.push_back(cycle_count);
    end else begin
      mmio_wr_valid = 1'b1;
      mmio_wr_data  = data;
      apply_write_model(byte_addr, data);
    end
    @(posedge clk);
    #2;
    mmio_rd_valid = 1'b0;
    mmio_wr_valid = 1'b0;
  endtask

  // Responses are sampled mid-cycle, in issue order
  always @(negedge clk) begin
    if (!reset) begin
      if (rsp_valid === 1'b1) begin
        if (exp_tid_q.size() == 0) begin
          stop_run("A response came back with no read outstanding");
        end else if (cycle_count != exp_cycle_q[0] + 2) begin
          stop_run($sformatf("Error at %0d ns: response after %0d cycles, expected 2",
                             $time, cycle_count - exp_cycle_q[0]));
        end else begin
          check_tid("rsp_tid", rsp_tid, exp_tid_q[0]);
          check_data("rsp_data", rsp_data, exp_data_q[0]);
          void'(exp_tid_q.pop_front());
          void'(exp_data_q.pop_front());
          void'(exp_cycle_q.pop_front());
        end
      end else if (rsp_valid !== 1'b0) begin
        stop_run("rsp_valid is unknown after reset");
      end else if (exp_tid_q.size() > 0 && cycle_count > exp_cycle_q[0] + 8) begin
        stop_run("Timed out waiting for the response to a read");
      end
    end
  end

  task automatic wait_responses_drained();
    int waited;
    waited = 0;
    while (exp_tid_q.size() > 0 && waited < 8) begin
      @(posedge clk);
      waited++;
    end
    if (exp_tid_q.size() > 0) begin
      stop_run("Timed out waiting for the last read responses");
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    int                  fd;
    int                  fields;
    string               line;
    byte                 op;
    logic [15:0]         byte_addr;
    csr_pkg::mmio_data_t data;
    int                  check_flag;

    mmio_rd_valid = 1'b0;
    mmio_wr_valid = 1'b0;
    mmio_address  = '0;
    mmio_tid      = '0;
    mmio_wr_data  = '0;
    reset         = 1'b1;
    lfsr_state    = 32'h5d1dbb51;
    exp_control   = '0;
    exp_dsm_base  = '0;
    for (int i = 0; i < csr_pkg::BUFFER_COUNT; i++) begin
      exp_buf_addr[i] = '0;
      exp_buf_size[i] = '0;
    end

    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    fd = $fopen("verification/accel_csr_testdata.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open the test data file");
    end
    while (!$feof(fd)) begin
      line   = "";
      fields = $fgets(line, fd);
      // Skip comments and blank lines
      if (fields > 0 && line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%c %h %h %d", op, byte_addr, data, check_flag);
        if (fields != 4) begin
          stop_run($sformatf("Malformed test data line: %s", line));
        end
        issue_op(op, byte_addr, data);
        if (check_flag != 0) begin
          // A write lands on the outputs one edge after its decode
          @(posedge clk);
          #1;
          check_outputs();
          #1;
        end
      end
    end
    $fclose(fd);

    wait_responses_drained();
    // Idle tail catches any stray response
    repeat (4) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule : accel_csr_tb

// ==== src/accel_csr_top.sv ====
// Top of the accelerator CSR block, wires the MMIO decoder, register file and read responder
module accel_csr_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mmio_rd_valid,
  input  logic                 mmio_wr_valid,
  input  csr_pkg::mmio_addr_t  mmio_address,
  input  csr_pkg::mmio_tid_t   mmio_tid,
  input  csr_pkg::mmio_data_t  mmio_wr_data,
  output logic                 rsp_valid,
  output csr_pkg::mmio_tid_t   rsp_tid,
  output csr_pkg::mmio_data_t  rsp_data,
  output csr_pkg::hc_control_t hc_control,
  output csr_pkg::cl_addr_t    hc_dsm_base,
  output csr_pkg::cl_addr_t    buffer_address [csr_pkg::BUFFER_COUNT],
  output csr_pkg::buf_size_t   buffer_size [csr_pkg::BUFFER_COUNT]
);

  // Decoded request, one cycle behind the channel
  logic                dec_rd;
  logic                dec_wr;
  csr_pkg::reg_index_t dec_index;
  csr_pkg::buf_slot_t  dec_slot;
  csr_pkg::mmio_tid_t  dec_tid;
  csr_pkg::mmio_data_t dec_wr_data;

  // ==================================================
  // Decode
  // ==================================================

  mmio_request_decode u_decode (
    .clk           (clk),
    .reset         (reset),
    .mmio_rd_valid (mmio_rd_valid),
    .mmio_wr_valid (mmio_wr_valid),
    .mmio_address  (mmio_address),
    .mmio_tid      (mmio_tid),
    .mmio_wr_data  (mmio_wr_data),
    .dec_rd        (dec_rd),
    .dec_wr        (dec_wr),
    .dec_index     (dec_index),
    .dec_slot      (dec_slot),
    .dec_tid       (dec_tid),
    .dec_wr_data   (dec_wr_data)
  );

  // ==================================================
  // Execute and respond
  // ==================================================

  csr_register_file u_regs (
    .clk            (clk),
    .reset          (reset),
    .dec_wr         (dec_wr),
    .dec_index      (dec_index),
    .dec_slot       (dec_slot),
    .dec_wr_data    (dec_wr_data),
    .hc_control     (hc_control),
    .hc_dsm_base    (hc_dsm_base),
    .buffer_address (buffer_address),
    .buffer_size    (buffer_size)
  );

  // Readback taps the register file outputs directly
  mmio_read_response u_response (
    .clk            (clk),
    .reset          (reset),
    .dec_rd         (dec_rd),
    .dec_index      (dec_index),
    .dec_slot       (dec_slot),
    .dec_tid        (dec_tid),
    .hc_control     (hc_control),
    .hc_dsm_base    (hc_dsm_base),
    .buffer_address (buffer_address),
    .buffer_size    (buffer_size),
    .rsp_valid      (rsp_valid),
    .rsp_tid        (rsp_tid),
    .rsp_data       (rsp_data)
  );

endmodule : accel_csr_top

// ==== src/mmio_read_response.sv ====
// Last stage of the CSR block, answers every decoded read with feature list or register data
module mmio_read_response (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 dec_rd,
  input  csr_pkg::reg_index_t  dec_index,
  input  csr_pkg::buf_slot_t   dec_slot,
  input  csr_pkg::mmio_tid_t   dec_tid,
  input  csr_pkg::hc_control_t hc_control,
  input  csr_pkg::cl_addr_t    hc_dsm_base,
  input  csr_pkg::cl_addr_t    buffer_address [csr_pkg::BUFFER_COUNT],
  input  csr_pkg::buf_size_t   buffer_size [csr_pkg::BUFFER_COUNT],
  output logic                 rsp_valid,
  output csr_pkg::mmio_tid_t   rsp_tid,
  output csr_pkg::mmio_data_t  rsp_data
);

  csr_pkg::mmio_data_t read_data;

  // ==================================================
  // Read mux
  // ==================================================

  // Registers are read after any write one cycle ahead has landed
  always_comb begin
    read_data = '0;
    case (dec_index)
      csr_pkg::REG_DFH:      read_data = csr_pkg::DFH_VALUE;
      csr_pkg::REG_AFU_ID_L: read_data = csr_pkg::AFU_ID[63:0];
      csr_pkg::REG_AFU_ID_H: read_data = csr_pkg::AFU_ID[127:64];
      // Stored in lines, returned as a byte address
      csr_pkg::REG_DSM_BASE: begin
        read_data = csr_pkg::mmio_data_t'(hc_dsm_base) << csr_pkg::CL_SHIFT;
      end
      csr_pkg::REG_CONTROL:  read_data = csr_pkg::mmio_data_t'(hc_control);
      csr_pkg::REG_BUF_ADDR: begin
        read_data = csr_pkg::mmio_data_t'(buffer_address[dec_slot]);
      end
      csr_pkg::REG_BUF_SIZE: begin
        read_data = csr_pkg::mmio_data_t'(buffer_size[dec_slot]);
      end
      // Reserved words and unmapped space read as zero
      default:               read_data = '0;
    endcase
  end

  // ==================================================
  // Response register
  // ==================================================

  // One response per read, no back-pressure
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= dec_rd;
    end
  end

  // Tag and data only load on a read, held otherwise
  always_ff @(posedge clk) begin
    if (dec_rd) begin
      rsp_tid  <= dec_tid;
      rsp_data <= read_data;
    end
  end

endmodule : mmio_read_response

// ==== src/csr_register_file.sv ====
// Holds the writable accelerator settings and applies decoded MMIO writes to them
module csr_register_file (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 dec_wr,
  input  csr_pkg::reg_index_t  dec_index,
  input  csr_pkg::buf_slot_t   dec_slot,
  input  csr_pkg::mmio_data_t  dec_wr_data,
  output csr_pkg::hc_control_t hc_control,
  output csr_pkg::cl_addr_t    hc_dsm_base,
  output csr_pkg::cl_addr_t    buffer_address [csr_pkg::BUFFER_COUNT],
  output csr_pkg::buf_size_t   buffer_size [csr_pkg::BUFFER_COUNT]
);

  logic wr_dsm_base;
  logic wr_control;
  logic wr_buf_addr;
  logic wr_buf_size;

  // ==================================================
  // Write selects
  // ==================================================

  // Read-only and unmapped indices match nothing here
  assign wr_dsm_base = dec_wr && (dec_index == csr_pkg::REG_DSM_BASE);
  assign wr_control  = dec_wr && (dec_index == csr_pkg::REG_CONTROL);
  assign wr_buf_addr = dec_wr && (dec_index == csr_pkg::REG_BUF_ADDR);
  assign wr_buf_size = dec_wr && (dec_index == csr_pkg::REG_BUF_SIZE);

  // ==================================================
  // Status memory base and control
  // ==================================================

  // Host writes a byte address, stored in cache lines
  always_ff @(posedge clk) begin
    if (reset) begin
      hc_dsm_base <= '0;
    end else if (wr_dsm_base) begin
      hc_dsm_base <= csr_pkg::cl_addr_t'(dec_wr_data >> csr_pkg::CL_SHIFT);
    end
  end

  // Control word lives in the low half
  always_ff @(posedge clk) begin
    if (reset) begin
      hc_control <= '0;
    end else if (wr_control) begin
      hc_control <= csr_pkg::hc_control_t'(dec_wr_data[31:0]);
    end
  end

  // ==================================================
  // Buffer descriptor table
  // ==================================================

  // Address written directly as a line address, no shift
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < csr_pkg::BUFFER_COUNT; i++) begin
        buffer_address[i] <= '0;
      end
    end else if (wr_buf_addr) begin
      buffer_address[dec_slot] <= csr_pkg::cl_addr_t'(dec_wr_data);
    end
  end

  // Size in bytes, upper data bits dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < csr_pkg::BUFFER_COUNT; i++) begin
        buffer_size[i] <= '0;
      end
    end else if (wr_buf_size) begin
      buffer_size[dec_slot] <= csr_pkg::buf_size_t'(dec_wr_data[31:0]);
    end
  end

endmodule : csr_register_file

// ==== src/mmio_request_decode.sv ====
// First stage of the CSR block, registers each MMIO request and maps its address to a register
module mmio_request_decode (
  input  logic                clk,
  input  logic                reset,
  input  logic                mmio_rd_valid,
  input  logic                mmio_wr_valid,
  input  csr_pkg::mmio_addr_t mmio_address,
  input  csr_pkg::mmio_tid_t  mmio_tid,
  input  csr_pkg::mmio_data_t mmio_wr_data,
  output logic                dec_rd,
  output logic                dec_wr,
  output csr_pkg::reg_index_t dec_index,
  output csr_pkg::buf_slot_t  dec_slot,
  output csr_pkg::mmio_tid_t  dec_tid,
  output csr_pkg::mmio_data_t dec_wr_data
);

  // Word offset into the descriptor table
  csr_pkg::mmio_addr_t desc_offset;
  logic                in_desc_table;
  csr_pkg::reg_index_t next_index;
  csr_pkg::buf_slot_t  next_slot;

  // ==================================================
  // Address match
  // ==================================================

  // Addresses below the table wrap to a large offset and fall out of range
  assign desc_offset   = mmio_address - csr_pkg::WORD_BUF_BASE;
  assign in_desc_table = desc_offset < csr_pkg::mmio_addr_t'(csr_pkg::BUFFER_COUNT * 4);

  always_comb begin
    // Slot only matters for descriptor accesses
    next_slot  = desc_offset[3:2];
    next_index = csr_pkg::REG_NONE;
    case (mmio_address)
      csr_pkg::WORD_DFH:      next_index = csr_pkg::REG_DFH;
      csr_pkg::WORD_AFU_ID_L: next_index = csr_pkg::REG_AFU_ID_L;
      csr_pkg::WORD_AFU_ID_H: next_index = csr_pkg::REG_AFU_ID_H;
      csr_pkg::WORD_RSVD0:    next_index = csr_pkg::REG_RSVD;
      csr_pkg::WORD_RSVD1:    next_index = csr_pkg::REG_RSVD;
      csr_pkg::WORD_DSM_BASE: next_index = csr_pkg::REG_DSM_BASE;
      csr_pkg::WORD_CONTROL:  next_index = csr_pkg::REG_CONTROL;
      default: begin
        // Each slot is four words, address pair then size pair
        // Odd words hit the upper half of a 64-bit register, not mapped
        if (in_desc_table && !desc_offset[0]) begin
          if (desc_offset[1]) begin
            next_index = csr_pkg::REG_BUF_SIZE;
          end else begin
            next_index = csr_pkg::REG_BUF_ADDR;
          end
        end
      end
    endcase
  end

  // ==================================================
  // Request register
  // ==================================================

  // Strobes are control state
  always_ff @(posedge clk) begin
    if (reset) begin
      dec_rd <= 1'b0;
      dec_wr <= 1'b0;
    end else begin
      dec_rd <= mmio_rd_valid;
      dec_wr <= mmio_wr_valid;
    end
  end

  // Payload follows the strobe, qualified downstream
  always_ff @(posedge clk) begin
    dec_index   <= next_index;
    dec_slot    <= next_slot;
    dec_tid     <= mmio_tid;
    dec_wr_data <= mmio_wr_data;
  end

endmodule : mmio_request_decode

// ==== src/csr_pkg.sv ====
// Shared widths, MMIO register map and feature list constants for the accelerator CSR block
package csr_pkg;

  // ==================================================
  // Widths that carry a meaning
  // ==================================================

  // MMIO address counts 32-bit words
  typedef logic [15:0]  mmio_addr_t;
  typedef logic [8:0]   mmio_tid_t;
  typedef logic [63:0]  mmio_data_t;
  // Host physical address in 64-byte lines
  typedef logic [41:0]  cl_addr_t;
  typedef logic [31:0]  hc_control_t;
  typedef logic [31:0]  buf_size_t;
  typedef logic [3:0]   reg_index_t;
  typedef logic [1:0]   buf_slot_t;

  // ==================================================
  // Sizes and conversions
  // ==================================================

  localparam int BUFFER_COUNT = 4;
  // 64 bytes per cache line
  localparam int CL_SHIFT = 6;

  // ==================================================
  // Register map
  // ==================================================

  // Byte addresses as software sees them
  localparam mmio_addr_t BYTE_DFH       = 16'h0000;
  localparam mmio_addr_t BYTE_AFU_ID_L  = 16'h0008;
  localparam mmio_addr_t BYTE_AFU_ID_H  = 16'h0010;
  localparam mmio_addr_t BYTE_RSVD0     = 16'h0018;
  localparam mmio_addr_t BYTE_RSVD1     = 16'h0020;
  localparam mmio_addr_t BYTE_DSM_BASE  = 16'h0110;
  localparam mmio_addr_t BYTE_CONTROL   = 16'h0118;
  // Slot n address at 0x120 + 16n, size 8 bytes above it
  localparam mmio_addr_t BYTE_BUF_BASE  = 16'h0120;

  // Same map in word units, as carried on the channel
  localparam mmio_addr_t WORD_DFH       = BYTE_DFH >> 2;
  localparam mmio_addr_t WORD_AFU_ID_L  = BYTE_AFU_ID_L >> 2;
  localparam mmio_addr_t WORD_AFU_ID_H  = BYTE_AFU_ID_H >> 2;
  localparam mmio_addr_t WORD_RSVD0     = BYTE_RSVD0 >> 2;
  localparam mmio_addr_t WORD_RSVD1     = BYTE_RSVD1 >> 2;
  localparam mmio_addr_t WORD_DSM_BASE  = BYTE_DSM_BASE >> 2;
  localparam mmio_addr_t WORD_CONTROL   = BYTE_CONTROL >> 2;
  localparam mmio_addr_t WORD_BUF_BASE  = BYTE_BUF_BASE >> 2;

  // Decoded register indices
  localparam reg_index_t REG_DFH       = 4'd0;
  localparam reg_index_t REG_AFU_ID_L  = 4'd1;
  localparam reg_index_t REG_AFU_ID_H  = 4'd2;
  localparam reg_index_t REG_RSVD      = 4'd3;
  localparam reg_index_t REG_DSM_BASE  = 4'd4;
  localparam reg_index_t REG_CONTROL   = 4'd5;
  localparam reg_index_t REG_BUF_ADDR  = 4'd6;
  localparam reg_index_t REG_BUF_SIZE  = 4'd7;
  localparam reg_index_t REG_NONE      = 4'd15;

  // ==================================================
  // Device feature list
  // ==================================================

  localparam logic [127:0] AFU_ID = 128'h6e3a41c7_9b204d5f_a8e137c0_52f9b4d6;
  // Feature type AFU in [63:60], end of list in bit 40
  localparam mmio_data_t DFH_VALUE = 64'h1000_0100_0000_0000;

endpackage : csr_pkg
